/* hdl/dmm_cfg.svh */
// shared constants for the multimeter control fabric
// addresses 7..10 are only decoded in the low 7 address bits
// address bit 7 set selects a read frame, clear a write frame
`ifndef DMM_CFG_SVH
`define DMM_CFG_SVH

//////////////////////////////////////////////////
// spi frame
`define DMM_ADDR_W          8                          // address field, sent first
`define DMM_REG_W           32                         // data field and register width
`define DMM_FRAME_W         (`DMM_ADDR_W + `DMM_REG_W) // 40 bits per frame

//////////////////////////////////////////////////
// register map
`define DMM_ADDR_LED        8'h07
`define DMM_ADDR_MODE       8'h08
`define DMM_ADDR_DIRECT     8'h09
`define DMM_ADDR_DURATION   8'h0a

//////////////////////////////////////////////////
// conditioning vector
`define DMM_NUM_BITS        29            // 4x4 mux + 8 monitor + 5 singles
`define DMM_DURATION_RESET  32'd20        // sample duration in clk cycles after reset
`define DMM_AZMUX_PC        4'b1001       // azmux enable + S2, the pre-charged signal

`endif

/* hdl/dmm_pkg.sv */
// types shared by the fabric and its checker
// cond_out_t bit order matches the board index map, azmux at bit 0
package dmm_pkg;

  // conditioning output vector, msb first
  typedef struct packed {
    logic       spi_interrupt;  // bit 28
    logic       meas_complete;  // bit 27
    logic       cmpr_latch;     // bit 26
    logic [3:0] adcmux;         // 25..22, adc current switches
    logic [7:0] monitor;        // 21..14
    logic       led0;           // bit 13
    logic       sig_pc_sw;      // bit 12, pre-charge switch
    logic [3:0] himux2;         // 11..8
    logic [3:0] himux;          // 7..4
    logic [3:0] azmux;          // 3..0, {en, a2, a1, a0}
  } cond_out_t;

  // source of the conditioning vector
  typedef enum logic [2:0] {
    MODE_IDLE    = 3'd0,  // all low, led follows reg_led
    MODE_ONES    = 3'd1,  // all high
    MODE_PATTERN = 3'd2,  // free running counter
    MODE_DIRECT  = 3'd3,  // direct register
    MODE_AZ      = 3'd4,  // auto-zero modulation
    MODE_PC      = 3'd5,  // pre-charge modulation
    MODE_OFF6    = 3'd6,
    MODE_OFF7    = 3'd7
  } mode_t;

  // auto-zero phases
  typedef enum logic {
    AZ_SIG = 1'b0,  // signal through pre-charge path
    AZ_LO  = 1'b1   // lo reference
  } az_state_t;

  // spi slave frame position
  typedef enum logic [1:0] {
    SPI_IDLE = 2'd0,
    SPI_ADDR = 2'd1,
    SPI_DATA = 2'd2
  } spi_state_t;

endpackage

/* hdl/spi_reg_bank.sv */
// spi slave register bank in mode 0 with 40-bit frames sent msb first
// spi pins are plain levels sampled in the clk domain after a 2-flop sync
// each spi half period must span at least 4 clk cycles
// short frames write nothing and bits beyond the 40th are ignored
`timescale 1ns/1ps
`include "dmm_cfg.svh"

module spi_reg_bank import dmm_pkg::*;
(
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  spi_clk,
  input  logic                  spi_cs,        // active low
  input  logic                  spi_mosi,
  output logic                  spi_miso,
  output logic                  reg_led,
  output mode_t                 reg_mode,
  output cond_out_t             reg_direct,
  output logic [`DMM_REG_W-1:0] reg_duration
);

  localparam int cnt_w = $clog2(`DMM_FRAME_W + 1);
  localparam logic [cnt_w-1:0] last_addr_bit = cnt_w'(`DMM_ADDR_W - 1);
  localparam logic [cnt_w-1:0] first_data_bit = cnt_w'(`DMM_ADDR_W);
  localparam logic [cnt_w-1:0] last_bit = cnt_w'(`DMM_FRAME_W - 1);
  localparam logic [cnt_w-1:0] frame_end = cnt_w'(`DMM_FRAME_W);

  logic [2:0]              sclk_sync;   // extra stage for edge detect
  logic [1:0]              cs_sync;
  logic [1:0]              mosi_sync;
  logic                    sclk_rise;
  logic                    sclk_fall;
  logic                    cs_s;
  logic                    mosi_s;
  spi_state_t              state_q;
  logic [cnt_w-1:0]        cnt_q;       // bits sampled so far in this frame
  logic                    rd_active;
  logic [`DMM_ADDR_W-2:0]  addr_sr;
  logic [`DMM_ADDR_W-1:0]  addr_nxt;
  logic [`DMM_ADDR_W-1:0]  addr_q;
  logic [`DMM_REG_W-2:0]   data_sr;
  logic [`DMM_REG_W-1:0]   wr_data;
  logic [`DMM_REG_W-1:0]   rd_value;
  logic [`DMM_REG_W-1:0]   rd_shift;
  logic                    wr_en;
  logic                    rd_load;
  logic                    miso_shift;

  //////////////////////////////////////////////////
  // synchronizers
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      sclk_sync <= '0;
      cs_sync   <= '1;      // deselected
      mosi_sync <= '0;
    end
    else
    begin
      sclk_sync <= {sclk_sync[1:0], spi_clk};
      cs_sync   <= {cs_sync[0], spi_cs};
      mosi_sync <= {mosi_sync[0], spi_mosi};
    end
  end

  assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
  assign sclk_fall = ~sclk_sync[1] & sclk_sync[2];
  assign cs_s      = cs_sync[1];
  assign mosi_s    = mosi_sync[1];     // same delay as sclk_sync[1]

  // address and data including the bit sampled on this edge
  assign addr_nxt = {addr_sr, mosi_s};
  assign wr_data  = {data_sr, mosi_s};

  //////////////////////////////////////////////////
  // frame fsm
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state_q   <= SPI_IDLE;
      cnt_q     <= '0;
      rd_active <= 1'b0;
    end
    else if (cs_s)
    begin
      state_q   <= SPI_IDLE;   // frame ends or is cut short
      cnt_q     <= '0;
      rd_active <= 1'b0;
    end
    else
    begin
      unique case (state_q)
        SPI_IDLE: state_q <= SPI_ADDR;
        SPI_ADDR:
        begin
          if (sclk_rise)
          begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == last_addr_bit)
            begin
              state_q   <= SPI_DATA;
              rd_active <= addr_nxt[`DMM_ADDR_W-1];
            end
          end
        end
        SPI_DATA:
        begin
          if (sclk_rise && cnt_q < frame_end)
            cnt_q <= cnt_q + 1'b1;   // saturates so extra bits are ignored
        end
        default: state_q <= SPI_IDLE;
      endcase
    end
  end

  assign wr_en = (state_q == SPI_DATA) && sclk_rise && (cnt_q == last_bit)
                 && !addr_q[`DMM_ADDR_W-1];
  assign rd_load = (state_q == SPI_ADDR) && sclk_rise && (cnt_q == last_addr_bit)
                   && addr_nxt[`DMM_ADDR_W-1];
  // no shift on the fall right after the address as the msb is already out
  assign miso_shift = (state_q == SPI_DATA) && sclk_fall && rd_active
                      && (cnt_q > first_data_bit);

  //////////////////////////////////////////////////
  // shift registers
  always_ff @(posedge clk)
  begin
    if (state_q == SPI_ADDR && sclk_rise)
      addr_sr <= addr_nxt[`DMM_ADDR_W-2:0];
    if (state_q == SPI_ADDR && sclk_rise && cnt_q == last_addr_bit)
      addr_q <= addr_nxt;                        // keep for the write at frame end
    if (state_q == SPI_DATA && sclk_rise && cnt_q < frame_end)
      data_sr <= wr_data[`DMM_REG_W-2:0];
    if (rd_load)
      rd_shift <= rd_value;
    else if (miso_shift)
      rd_shift <= {rd_shift[`DMM_REG_W-2:0], 1'b0};
  end

  assign spi_miso = rd_active & rd_shift[`DMM_REG_W-1];   // low outside reads

  // readback mux with narrow registers zero extended
  always_comb
  begin
    case ({1'b0, addr_nxt[`DMM_ADDR_W-2:0]})
      `DMM_ADDR_LED:      rd_value = {{(`DMM_REG_W-1){1'b0}}, reg_led};
      `DMM_ADDR_MODE:     rd_value = {{(`DMM_REG_W-3){1'b0}}, reg_mode};
      `DMM_ADDR_DIRECT:   rd_value = {{(`DMM_REG_W-`DMM_NUM_BITS){1'b0}}, reg_direct};
      `DMM_ADDR_DURATION: rd_value = reg_duration;
      default:            rd_value = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // register bank
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      reg_led      <= 1'b0;
      reg_mode     <= MODE_IDLE;
      reg_direct   <= '0;
      reg_duration <= `DMM_DURATION_RESET;
    end
    else if (wr_en)
    begin
      case ({1'b0, addr_q[`DMM_ADDR_W-2:0]})
        `DMM_ADDR_LED:      reg_led      <= wr_data[0];
        `DMM_ADDR_MODE:     reg_mode     <= mode_t'(wr_data[2:0]);
        `DMM_ADDR_DIRECT:   reg_direct   <= cond_out_t'(wr_data[`DMM_NUM_BITS-1:0]);
        `DMM_ADDR_DURATION: reg_duration <= wr_data;
        default: ;                                  // unmapped addresses are dropped
      endcase
    end
  end

endmodule

/* hdl/modulation_az.sv */
// auto-zero sequencer, alternates signal and lo phases of the azmux
// each phase lasts reg_duration cycles, 0 behaves as 1
// any change of reg_duration restarts in the signal phase
`timescale 1ns/1ps
`include "dmm_cfg.svh"

module modulation_az import dmm_pkg::*;
(
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic [`DMM_REG_W-1:0] reg_duration,
  input  cond_out_t             reg_direct,
  output cond_out_t             az_out
);

  logic [`DMM_REG_W-1:0] dur_q;     // duration the count was started with
  logic [`DMM_REG_W-1:0] cnt_q;     // cycles into the current phase
  logic [`DMM_REG_W-1:0] last_cnt;
  az_state_t             state_q;
  logic                  led_q;
  logic                  chg_q;     // one cycle pulse per phase change

  assign last_cnt = (reg_duration == '0) ? '0 : reg_duration - 1'b1;

  //////////////////////////////////////////////////
  // phase timer
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      dur_q   <= `DMM_DURATION_RESET;   // matches reg bank, no restart after reset
      cnt_q   <= '0;
      state_q <= AZ_SIG;
      led_q   <= 1'b0;
      chg_q   <= 1'b0;
    end
    else
    begin
      chg_q <= 1'b0;
      if (reg_duration != dur_q)
      begin
        dur_q   <= reg_duration;        // restart
        cnt_q   <= '0;
        state_q <= AZ_SIG;
      end
      else if (cnt_q >= last_cnt)
      begin
        cnt_q <= '0;
        chg_q <= 1'b1;
        if (state_q == AZ_SIG)
          state_q <= AZ_LO;
        else
        begin
          state_q <= AZ_SIG;
          led_q   <= ~led_q;            // blink once per signal phase
        end
      end
      else
        cnt_q <= cnt_q + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // output vector
  always_comb
  begin
    az_out = reg_direct;       // himux, himux2, adc and singles pass through
    if (state_q == AZ_SIG)
    begin
      az_out.sig_pc_sw = 1'b1;
      az_out.azmux     = `DMM_AZMUX_PC;
    end
    else
    begin
      az_out.sig_pc_sw = 1'b0;
      az_out.azmux     = reg_direct.azmux;   // lo value from the mcu
    end
    az_out.led0    = led_q;
    az_out.monitor = {6'b0, chg_q, state_q == AZ_SIG};  // mon0 high in signal phase
  end

endmodule

/* hdl/modulation_pc.sv */
// pre-charge sequencer, toggles the pre-charge switch each sample period
// period is reg_duration cycles, 0 behaves as 1
// any change of reg_duration restarts with the switch low
`timescale 1ns/1ps
`include "dmm_cfg.svh"

module modulation_pc import dmm_pkg::*;
(
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic [`DMM_REG_W-1:0] reg_duration,
  input  cond_out_t             reg_direct,
  output cond_out_t             pc_out
);

  logic [`DMM_REG_W-1:0] dur_q;
  logic [`DMM_REG_W-1:0] cnt_q;
  logic [`DMM_REG_W-1:0] last_cnt;
  logic                  pc_q;      // switch state

  assign last_cnt = (reg_duration == '0) ? '0 : reg_duration - 1'b1;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      dur_q <= `DMM_DURATION_RESET;
      cnt_q <= '0;
      pc_q  <= 1'b0;
    end
    else if (reg_duration != dur_q)
    begin
      dur_q <= reg_duration;   // new duration, start over
      cnt_q <= '0;
      pc_q  <= 1'b0;
    end
    else if (cnt_q >= last_cnt)
    begin
      cnt_q <= '0;
      pc_q  <= ~pc_q;
    end
    else
      cnt_q <= cnt_q + 1'b1;
  end

  // azmux stays under mcu control here
  always_comb
  begin
    pc_out            = reg_direct;
    pc_out.sig_pc_sw  = pc_q;
    pc_out.led0       = pc_q;      // visible on the board
    pc_out.monitor[0] = pc_q;      // scope trigger
  end

endmodule

/* hdl/mode_select.sv */
// selects the source of the conditioning vector from reg_mode
// output is registered, one clk behind its sources
// test pattern counter runs in every mode and wraps at 2^29
`timescale 1ns/1ps
`include "dmm_cfg.svh"

module mode_select import dmm_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  input  mode_t     reg_mode,
  input  logic      reg_led,
  input  cond_out_t reg_direct,
  input  cond_out_t az_out,
  input  cond_out_t pc_out,
  output cond_out_t cond
);

  logic [`DMM_NUM_BITS-1:0] pattern_q;
  cond_out_t                cond_nxt;

  //////////////////////////////////////////////////
  // 8-way source mux
  always_comb
  begin
    cond_nxt = '0;
    case (reg_mode)
      MODE_IDLE:    cond_nxt.led0 = reg_led;   // rest low, board comes up quiet
      MODE_ONES:    cond_nxt = '1;
      MODE_PATTERN: cond_nxt = cond_out_t'(pattern_q);
      MODE_DIRECT:  cond_nxt = reg_direct;
      MODE_AZ:      cond_nxt = az_out;
      MODE_PC:      cond_nxt = pc_out;
      MODE_OFF6,
      MODE_OFF7:    cond_nxt = '0;
      default:      cond_nxt = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // pattern counter and output register
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      pattern_q <= '0;
      cond      <= '0;
    end
    else
    begin
      pattern_q <= pattern_q + 1'b1;   // walks every output pin
      cond      <= cond_nxt;
    end
  end

endmodule

/* hdl/dmm_top.sv */
// multimeter front end control fabric
// single clock domain, spi pins are sampled asynchronously to clk
// cond follows a register write within 6 clk cycles
`timescale 1ns/1ps
`include "dmm_cfg.svh"

module dmm_top import dmm_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  input  logic      spi_clk,
  input  logic      spi_cs,     // active low
  input  logic      spi_mosi,
  output logic      spi_miso,
  output cond_out_t cond
);

  logic                  reg_led;
  mode_t                 reg_mode;
  cond_out_t             reg_direct;
  logic [`DMM_REG_W-1:0] reg_duration;   // sample duration in clk cycles
  cond_out_t             az_out;
  cond_out_t             pc_out;

  //////////////////////////////////////////////////
  // mcu registers
  spi_reg_bank reg_bank_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .spi_clk      (spi_clk),
    .spi_cs       (spi_cs),
    .spi_mosi     (spi_mosi),
    .spi_miso     (spi_miso),
    .reg_led      (reg_led),
    .reg_mode     (reg_mode),
    .reg_direct   (reg_direct),
    .reg_duration (reg_duration)
  );

  //////////////////////////////////////////////////
  // sequencers, both free running
  modulation_az az_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .reg_duration (reg_duration),
    .reg_direct   (reg_direct),   // lo azmux code and pass-through fields
    .az_out       (az_out)
  );

  modulation_pc pc_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .reg_duration (reg_duration),
    .reg_direct   (reg_direct),
    .pc_out       (pc_out)
  );

  //////////////////////////////////////////////////
  // output selection
  mode_select mode_sel_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .reg_mode   (reg_mode),
    .reg_led    (reg_led),
    .reg_direct (reg_direct),
    .az_out     (az_out),
    .pc_out     (pc_out),
    .cond       (cond)
  );

endmodule

/* tb/tb_clk_gen.sv */
// testbench clock and reset source
// reset is held low for reset_cycles rising edges, then released 10 ns later
`timescale 1ns/1ps

module tb_clk_gen
#(
  parameter int period_ns    = 100,
  parameter int reset_cycles = 8
)
(
  output logic clk,
  output logic arst_n
);

  initial
  begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;   // free running
  end

  initial
  begin
    arst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #10;
    arst_n = 1'b1;                          // released off the clock edge
  end

endmodule

/* tb/dmm_chk.sv */
// concurrent checks on the conditioning vector, bound into dmm_top
// cond is registered, so each check looks at the sources one clk back
// fail_cnt counts assertion failures for the testbench to pick up
`timescale 1ns/1ps
`include "dmm_cfg.svh"

module dmm_chk import dmm_pkg::*;
(
  input logic      clk,
  input logic      arst_n,
  input mode_t     reg_mode,
  input logic      reg_led,
  input cond_out_t reg_direct,
  input cond_out_t cond
);

  int                       fail_cnt = 0;
  cond_out_t                cond_no_led;    // cond with led0 masked off
  logic [`DMM_NUM_BITS-1:0] cond_bits;
  logic [`DMM_NUM_BITS-1:0] cond_inc;       // wraps at 2^29

  always_comb
  begin
    cond_no_led      = cond;
    cond_no_led.led0 = 1'b0;
  end

  assign cond_bits = cond;
  assign cond_inc  = cond_bits + 1'b1;

  //////////////////////////////////////////////////
  // static modes
  idle_quiet: assert property (@(posedge clk) disable iff (!arst_n)
    $past(reg_mode) == MODE_IDLE |-> cond_no_led == '0 && cond.led0 == $past(reg_led))
    else
    begin
      $error("idle mode drives more than the led");
      fail_cnt++;
    end

  ones_high: assert property (@(posedge clk) disable iff (!arst_n)
    $past(reg_mode) == MODE_ONES |-> cond == '1)
    else
    begin
      $error("ones mode has a low output");
      fail_cnt++;
    end

  direct_copy: assert property (@(posedge clk) disable iff (!arst_n)
    $past(reg_mode) == MODE_DIRECT |-> cond == $past(reg_direct))
    else
    begin
      $error("direct mode differs from reg_direct");
      fail_cnt++;
    end

  // counter step only once the mode has held for two cycles
  pattern_step: assert property (@(posedge clk) disable iff (!arst_n)
    $past(reg_mode) == MODE_PATTERN && $past(reg_mode, 2) == MODE_PATTERN
    |-> cond_bits == $past(cond_inc))
    else
    begin
      $error("pattern mode did not step by one");
      fail_cnt++;
    end

  off_low: assert property (@(posedge clk) disable iff (!arst_n)
    $past(reg_mode) inside {MODE_OFF6, MODE_OFF7} |-> cond == '0)
    else
    begin
      $error("modes 6 and 7 drive an output");
      fail_cnt++;
    end

  //////////////////////////////////////////////////
  // sequencer modes
  az_fields: assert property (@(posedge clk) disable iff (!arst_n)
    $past(reg_mode) == MODE_AZ
    |-> cond.himux == $past(reg_direct.himux) && cond.himux2 == $past(reg_direct.himux2)
        && cond.adcmux == $past(reg_direct.adcmux)
        && (cond.sig_pc_sw ? cond.azmux == `DMM_AZMUX_PC
                           : cond.azmux == $past(reg_direct.azmux)))
    else
    begin
      $error("auto-zero mode fields wrong");
      fail_cnt++;
    end

  pc_fields: assert property (@(posedge clk) disable iff (!arst_n)
    $past(reg_mode) == MODE_PC
    |-> cond.azmux == $past(reg_direct.azmux) && cond.led0 == cond.sig_pc_sw)
    else
    begin
      $error("pre-charge mode fields wrong");
      fail_cnt++;
    end

endmodule

bind dmm_top dmm_chk chk_i (
  .clk        (clk),
  .arst_n     (arst_n),
  .reg_mode   (reg_mode),
  .reg_led    (reg_led),
  .reg_direct (reg_direct),
  .cond       (cond)
);

/* tb/dmm_tb.sv */
// top testbench driving spi frames msb first with 4 clk half periods
// inputs change 10 ns after the rising clk edge
// random direct value and duration from a fixed seed
`timescale 1ns/1ps
`include "dmm_cfg.svh"

module dmm_tb import dmm_pkg::*;
();

  logic         clk;
  logic         arst_n;
  logic         spi_clk;
  logic         spi_cs;
  logic         spi_mosi;
  logic         spi_miso;
  cond_out_t    cond;
  integer       seed = 35581;
  logic [31:0]  direct_val;
  logic [31:0]  dur_val;

  tb_clk_gen clk_gen_i (
    .clk    (clk),
    .arst_n (arst_n)
  );

  dmm_top dut_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .spi_clk  (spi_clk),
    .spi_cs   (spi_cs),     // active low
    .spi_mosi (spi_mosi),
    .spi_miso (spi_miso),
    .cond     (cond)
  );

  //////////////////////////////////////////////////
  // error handling
  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp)
      stop_with_failure($sformatf("CHECK FAILED at %0t ns: %s, got %0h expected %0h",
                                  $time, what, got, exp));
  endtask

  // assertion failures in the bound checker
  always @(posedge clk)
  begin
    if (dut_i.chk_i.fail_cnt != 0)
      stop_with_failure("an assertion in the bound checker failed");
  end

  //////////////////////////////////////////////////
  // spi master
  task automatic half_period();
    repeat (4) @(posedge clk);
    #10;
  endtask

  task automatic spi_frame(input logic [7:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata);
    logic [`DMM_FRAME_W-1:0] frame;
    int                      i;
    frame = {addr, wdata};
    rdata = '0;
    @(posedge clk);
    #10;
    spi_cs = 1'b0;
    for (i = `DMM_FRAME_W - 1; i >= 0; i--)
    begin
      spi_mosi = frame[i];          // set up on the low half
      half_period();
      spi_clk = 1'b1;
      if (i < `DMM_REG_W)
        rdata[i] = spi_miso;        // miso settled since the last fall
      half_period();
      spi_clk = 1'b0;
    end
    spi_mosi = 1'b0;
    half_period();
    spi_cs = 1'b1;
    repeat (8) @(posedge clk);      // frame fsm back to idle
    #10;
  endtask

  task automatic spi_write(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    spi_frame(addr & 8'h7f, data, unused);
  endtask

  task automatic spi_read(input logic [7:0] addr, output logic [31:0] data);
    spi_frame(addr | 8'h80, 32'h0, data);
  endtask

  task automatic write_and_readback(input logic [7:0] addr, input logic [31:0] value,
                                    input logic [31:0] mask, input string what);
    logic [31:0] rd;
    spi_write(addr, value);
    spi_read(addr, rd);
    check_equal(rd, value & mask, what);
  endtask

  //////////////////////////////////////////////////
  // waits
  task automatic wait_for_reset_release();
    int guard;
    guard = 0;
    while (arst_n !== 1'b1 && guard < 50)
    begin
      @(posedge clk);
      guard++;
    end
    if (arst_n !== 1'b1)
      stop_with_failure("timed out waiting for the reset to be released");
    @(posedge clk);
    #10;
  endtask

  // cycles between two changes of sig_pc_sw at cond
  task automatic check_toggle_period(input int expected, input string what);
    logic prev;
    int   cycles;
    @(posedge clk);
    #10;
    prev   = cond.sig_pc_sw;
    cycles = 0;
    while (cond.sig_pc_sw == prev && cycles < 200)
    begin
      @(posedge clk);
      #10;
      cycles++;
    end
    if (cond.sig_pc_sw == prev)
      stop_with_failure($sformatf("timed out waiting for sig_pc_sw to toggle in %s", what));
    prev   = cond.sig_pc_sw;
    cycles = 0;
    while (cond.sig_pc_sw == prev && cycles < 200)
    begin
      @(posedge clk);
      #10;
      cycles++;
    end
    if (cond.sig_pc_sw == prev)
      stop_with_failure($sformatf("timed out waiting for the second toggle in %s", what));
    check_equal(cycles, expected, what);
  endtask

  //////////////////////////////////////////////////
  // stimulus
  initial
  begin
    spi_clk  = 1'b0;
    spi_cs   = 1'b1;
    spi_mosi = 1'b0;
    wait_for_reset_release();
    repeat (10) @(posedge clk);     // idle with led clear keeps cond at zero
    #10;

    direct_val = $random(seed) & 32'h1fff_ffff;       // 29 bit vector
    dur_val    = 32'd4 + ($unsigned($random(seed)) % 16);

    write_and_readback(`DMM_ADDR_LED, 32'd1, 32'h1, "led readback");
    write_and_readback(`DMM_ADDR_DIRECT, direct_val, 32'h1fff_ffff, "direct readback");
    write_and_readback(`DMM_ADDR_DURATION, dur_val, 32'hffff_ffff, "duration readback");
    write_and_readback(`DMM_ADDR_MODE, 32'(MODE_ONES), 32'h7, "mode readback");

    spi_write(`DMM_ADDR_MODE, 32'(MODE_PATTERN));
    repeat (40) @(posedge clk);
    spi_write(`DMM_ADDR_MODE, 32'(MODE_DIRECT));
    repeat (20) @(posedge clk);

    spi_write(`DMM_ADDR_MODE, 32'(MODE_AZ));
    check_toggle_period(dur_val, "auto-zero phase length");
    check_toggle_period(dur_val, "auto-zero phase length");
    spi_write(`DMM_ADDR_MODE, 32'(MODE_PC));
    check_toggle_period(dur_val, "pre-charge toggle period");

    spi_write(`DMM_ADDR_MODE, 32'(MODE_OFF6));
    repeat (20) @(posedge clk);
    spi_write(`DMM_ADDR_MODE, 32'(MODE_OFF7));
    repeat (20) @(posedge clk);
    spi_write(`DMM_ADDR_MODE, 32'(MODE_IDLE));
    spi_write(`DMM_ADDR_LED, 32'd0);
    repeat (20) @(posedge clk);
    #10;                            // let the checker finish the last edge

    if (dut_i.chk_i.fail_cnt != 0)
      stop_with_failure("an assertion in the bound checker failed");
    else
    begin
      $display("Test passed");
      $finish;
    end
  end

endmodule

/* project.f */
+incdir+hdl
hdl/dmm_pkg.sv
hdl/spi_reg_bank.sv
hdl/modulation_az.sv
hdl/modulation_pc.sv
hdl/mode_select.sv
hdl/dmm_top.sv
tb/tb_clk_gen.sv
tb/dmm_chk.sv
tb/dmm_tb.sv

/* Bender.yml */
package:
  name: dmm_fabric

export_include_dirs:
  - hdl

sources:
  # design, package first
  - target: any(rtl, test)
    files:
      - hdl/dmm_pkg.sv
      - hdl/spi_reg_bank.sv
      - hdl/modulation_az.sv
      - hdl/modulation_pc.sv
      - hdl/mode_select.sv
      - hdl/dmm_top.sv

  # testbench, top module dmm_tb
  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/dmm_chk.sv
      - tb/dmm_tb.sv
